// File: source/pagerank_pkg.sv
// Widths, array kinds and bus structs shared by all blocks of the PageRank vertex unit
`default_nettype none

package pagerank_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int VERTEX_ID_BITS  = 16;
	localparam int EDGE_INDEX_BITS = 16;
	localparam int RANK_BITS       = 32;
	localparam int WORD_BITS       = 32;
	// Kind bit on top of a 16-bit index
	localparam int ADDR_BITS       = 17;

	typedef enum logic {
		EDGE_ARRAY = 1'b0,
		RANK_ARRAY = 1'b1
	} array_kind_e;

	//////////////////////////////
	// Payloads
	//////////////////////////////

	typedef struct packed {
		logic [VERTEX_ID_BITS-1:0]  vertex_id;
		logic [EDGE_INDEX_BITS-1:0] edge_start;
		logic [EDGE_INDEX_BITS-1:0] out_degree;
	} vertex_job_t;

	// Bit image doubles as the Wishbone address
	typedef struct packed {
		array_kind_e          kind;
		logic [ADDR_BITS-2:0] index;
	} read_cmd_t;

	typedef struct packed {
		logic [WORD_BITS-VERTEX_ID_BITS-1:0] pad;
		logic [VERTEX_ID_BITS-1:0]           neighbour_id;
	} edge_entry_t;

	// Same memory word, read as an edge entry or as a rank
	typedef union packed {
		edge_entry_t          edge_view;
		logic [RANK_BITS-1:0] rank_view;
	} mem_word_u;

	typedef struct packed {
		logic [VERTEX_ID_BITS-1:0] vertex_id;
		logic [RANK_BITS-1:0]      sum;
	} vertex_result_t;

	//////////////////////////////
	// Wishbone requests
	//////////////////////////////

	typedef struct packed {
		logic        cyc;
		logic        stb;
		vertex_job_t dat;
	} wb_job_req_t;

	// Read only master, so no we
	typedef struct packed {
		logic      cyc;
		logic      stb;
		read_cmd_t adr;
	} wb_read_req_t;

endpackage

`default_nettype wire

// File: source/vertex_job_queue.sv
// Wishbone classic slave that accepts vertex jobs from the host and queues them for the FSM
`default_nettype none
`timescale 1ns/1ps

module vertex_job_queue #(
	parameter int JOB_QUEUE_DEPTH = 8
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  pagerank_pkg::wb_job_req_t job_req,
	output logic                      job_ack,
	input  logic                      job_pop,
	output logic                      job_valid,
	output pagerank_pkg::vertex_job_t job_head
);
	import pagerank_pkg::*;

	localparam int PTR_BITS = (JOB_QUEUE_DEPTH > 1) ? $clog2(JOB_QUEUE_DEPTH) : 1;

	vertex_job_t         job_mem [JOB_QUEUE_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   fill;
	logic                full;
	logic                accept;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(JOB_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full      = (fill == (PTR_BITS + 1)'(JOB_QUEUE_DEPTH));
	assign job_valid = (fill != '0);
	assign job_head  = job_mem[rd_ptr];

	// Ack cycle still shows the old stb, so it must not store twice
	assign accept = job_req.cyc && job_req.stb && !job_ack && !full;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_ack <= 1'b0;
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			fill    <= '0;
		end else begin
			job_ack <= accept;
			if (accept) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (job_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (accept && !job_pop) begin
				fill <= fill + 1'b1;
			end else if (job_pop && !accept) begin
				fill <= fill - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			job_mem[wr_ptr] <= job_req.dat;
		end
	end

endmodule

`default_nettype wire

// File: source/vertex_control.sv
// Per-vertex FSM: takes one job, issues its edge reads and reports the summed rank
`default_nettype none
`timescale 1ns/1ps

module vertex_control (
	input  logic                                     clock,
	input  logic                                     rstn,
	input  logic                                     job_valid,
	input  pagerank_pkg::vertex_job_t                job_head,
	output logic                                     job_pop,
	input  logic                                     edges_issued_done,
	input  logic                                     vertex_done,
	input  logic [pagerank_pkg::EDGE_INDEX_BITS-1:0] issued_count,
	output logic [pagerank_pkg::EDGE_INDEX_BITS-1:0] out_degree,
	output logic                                     count_clear,
	output logic                                     edge_cmd_valid,
	output pagerank_pkg::read_cmd_t                  edge_cmd,
	input  logic [pagerank_pkg::RANK_BITS-1:0]       sum,
	output logic                                     result_valid,
	output pagerank_pkg::vertex_result_t             result
);
	import pagerank_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		ISSUE,
		REPORT
	} state_e;

	state_e      state;
	state_e      state_next;
	vertex_job_t job_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Head is valid in the pop cycle, held for the whole vertex
	always_ff @(posedge clock) begin
		if (job_pop) begin
			job_q <= job_head;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (job_valid) begin
					state_next = LOAD;
				end
			end
			// No edges means nothing to read
			LOAD: begin
				state_next = (job_q.out_degree == '0) ? REPORT : ISSUE;
			end
			// vertex_done is high in the cycle of the last rank
			ISSUE: begin
				if (vertex_done) begin
					state_next = REPORT;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	assign job_pop        = (state == IDLE) && job_valid;
	assign count_clear    = (state == LOAD);
	assign out_degree     = job_q.out_degree;
	assign edge_cmd_valid = (state == ISSUE) && !edges_issued_done;
	assign edge_cmd       = '{kind: EDGE_ARRAY, index: job_q.edge_start + issued_count};
	assign result_valid   = (state == REPORT);
	assign result         = '{vertex_id: job_q.vertex_id, sum: sum};

endmodule

`default_nettype wire

// File: source/edge_counter.sv
// Edge counts of the current vertex against its out-degree, plus running vertex and edge totals
`default_nettype none
`timescale 1ns/1ps

module edge_counter (
	input  logic                                     clock,
	input  logic                                     rstn,
	input  logic                                     count_clear,
	input  logic [pagerank_pkg::EDGE_INDEX_BITS-1:0] out_degree,
	input  logic                                     edge_cmd_taken,
	input  logic                                     rank_valid,
	output logic                                     edges_issued_done,
	output logic                                     vertex_done,
	output logic [pagerank_pkg::EDGE_INDEX_BITS-1:0] issued_count,
	output logic [pagerank_pkg::WORD_BITS-1:0]       vertex_count,
	output logic [pagerank_pkg::WORD_BITS-1:0]       edge_count
);
	import pagerank_pkg::*;

	logic [EDGE_INDEX_BITS-1:0] returned_count;
	logic [EDGE_INDEX_BITS-1:0] returned_next;
	logic                       vertex_finish;

	// Looks ahead by the arriving rank so the result can follow in one cycle
	assign returned_next     = returned_count + EDGE_INDEX_BITS'(rank_valid);
	assign edges_issued_done = (issued_count == out_degree);
	assign vertex_done       = (returned_next == out_degree);

	// Last rank arriving, or an edgeless vertex being loaded
	assign vertex_finish = count_clear ? (out_degree == '0) : (rank_valid && vertex_done);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issued_count   <= '0;
			returned_count <= '0;
			vertex_count   <= '0;
			edge_count     <= '0;
		end else begin
			if (count_clear) begin
				issued_count   <= '0;
				returned_count <= '0;
			end else begin
				if (edge_cmd_taken) begin
					issued_count <= issued_count + 1'b1;
				end
				returned_count <= returned_next;
			end
			if (vertex_finish) begin
				vertex_count <= vertex_count + 1'b1;
			end
			if (rank_valid) begin
				edge_count <= edge_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/read_command_arbiter.sv
// Round-robin merge of edge and rank read requests into the command FIFO feeding the memory port
`default_nettype none
`timescale 1ns/1ps

module read_command_arbiter #(
	parameter int CMD_FIFO_DEPTH = 4
) (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    edge_cmd_valid,
	input  pagerank_pkg::read_cmd_t                 edge_cmd,
	output logic                                    edge_cmd_taken,
	input  logic                                    neighbour_valid,
	input  logic [pagerank_pkg::VERTEX_ID_BITS-1:0] neighbour_id,
	output logic                                    rank_slot_busy,
	input  logic                                    cmd_pop,
	output logic                                    cmd_valid,
	output pagerank_pkg::read_cmd_t                 cmd_head
);
	import pagerank_pkg::*;

	localparam int PTR_BITS = (CMD_FIFO_DEPTH > 1) ? $clog2(CMD_FIFO_DEPTH) : 1;

	read_cmd_t                 cmd_mem [CMD_FIFO_DEPTH];
	logic [PTR_BITS-1:0]       wr_ptr;
	logic [PTR_BITS-1:0]       rd_ptr;
	logic [PTR_BITS:0]         fill;
	logic                      slot_valid;
	logic [VERTEX_ID_BITS-1:0] slot_id;
	logic                      last_grant_rank;
	logic                      edge_req;
	logic                      rank_req;
	logic                      grant_edge;
	logic                      grant_rank;
	logic                      push;
	read_cmd_t                 push_cmd;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(CMD_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	//////////////////////////////
	// Arbitration
	//////////////////////////////

	// Edges leave the last entry free, so a pending neighbour always finds room
	assign edge_req = edge_cmd_valid && (fill < (PTR_BITS + 1)'(CMD_FIFO_DEPTH - 1));
	assign rank_req = slot_valid && (fill < (PTR_BITS + 1)'(CMD_FIFO_DEPTH));

	assign grant_edge = edge_req && (!rank_req || last_grant_rank);
	assign grant_rank = rank_req && (!edge_req || !last_grant_rank);
	assign push       = grant_edge || grant_rank;
	assign push_cmd   = grant_rank ? read_cmd_t'{kind: RANK_ARRAY, index: slot_id} : edge_cmd;

	assign edge_cmd_taken = grant_edge;
	// Neighbour in flight counts as occupied too
	assign rank_slot_busy = slot_valid || neighbour_valid;

	//////////////////////////////
	// Command FIFO
	//////////////////////////////

	assign cmd_valid = (fill != '0);
	assign cmd_head  = cmd_mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			slot_valid      <= 1'b0;
			last_grant_rank <= 1'b0;
			wr_ptr          <= '0;
			rd_ptr          <= '0;
			fill            <= '0;
		end else begin
			if (neighbour_valid) begin
				slot_valid <= 1'b1;
			end else if (grant_rank) begin
				slot_valid <= 1'b0;
			end
			if (push) begin
				last_grant_rank <= grant_rank;
				wr_ptr          <= next_ptr(wr_ptr);
			end
			if (cmd_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			if (push && !cmd_pop) begin
				fill <= fill + 1'b1;
			end else if (cmd_pop && !push) begin
				fill <= fill - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (neighbour_valid) begin
			slot_id <= neighbour_id;
		end
		if (push) begin
			cmd_mem[wr_ptr] <= push_cmd;
		end
	end

endmodule

`default_nettype wire

// File: source/memory_read_port.sv
// Wishbone classic read master that drains the command FIFO and steers each reply by array kind
`default_nettype none
`timescale 1ns/1ps

module memory_read_port (
	input  logic                                    clock,
	input  logic                                    rstn,
	output logic                                    cmd_pop,
	input  logic                                    cmd_valid,
	input  pagerank_pkg::read_cmd_t                 cmd_head,
	input  logic                                    rank_slot_busy,
	output pagerank_pkg::wb_read_req_t              mem_req,
	input  logic                                    mem_ack,
	input  pagerank_pkg::mem_word_u                 mem_dat,
	output logic                                    neighbour_valid,
	output logic [pagerank_pkg::VERTEX_ID_BITS-1:0] neighbour_id,
	output logic                                    rank_valid,
	output logic [pagerank_pkg::RANK_BITS-1:0]      rank_value
);
	import pagerank_pkg::*;

	logic        busy;
	read_cmd_t   adr_q;
	logic        resp_valid;
	array_kind_e resp_kind;
	mem_word_u   resp_word;

	// One read at a time, and none while a neighbour waits for placement
	assign cmd_pop = !busy && cmd_valid && !rank_slot_busy;
	assign mem_req = '{cyc: busy, stb: busy, adr: adr_q};

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy       <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= busy && mem_ack;
			if (cmd_pop) begin
				busy <= 1'b1;
			end else if (mem_ack) begin
				busy <= 1'b0;
			end
		end
	end

	// Kind of the read in flight rides in the address
	always_ff @(posedge clock) begin
		if (cmd_pop) begin
			adr_q <= cmd_head;
		end
		if (busy && mem_ack) begin
			resp_kind <= adr_q.kind;
			resp_word <= mem_dat;
		end
	end

	//////////////////////////////
	// Reply routing
	//////////////////////////////

	assign neighbour_valid = resp_valid && (resp_kind == EDGE_ARRAY);
	assign neighbour_id    = resp_word.edge_view.neighbour_id;
	assign rank_valid      = resp_valid && (resp_kind == RANK_ARRAY);
	assign rank_value      = resp_word.rank_view;

endmodule

`default_nettype wire

// File: source/rank_accumulator.sv
// Wrapping sum of the neighbour ranks of the vertex in progress
`default_nettype none
`timescale 1ns/1ps

module rank_accumulator (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               count_clear,
	input  logic                               rank_valid,
	input  logic [pagerank_pkg::RANK_BITS-1:0] rank_value,
	output logic [pagerank_pkg::RANK_BITS-1:0] sum
);

	// Overflow wraps modulo 2^32
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum <= '0;
		end else if (count_clear) begin
			sum <= '0;
		end else if (rank_valid) begin
			sum <= sum + rank_value;
		end
	end

endmodule

`default_nettype wire

// File: source/pagerank_vertex_unit.sv
// Top of the PageRank vertex unit; connects the job queue, FSM, counters, arbiter and memory port
`default_nettype none
`timescale 1ns/1ps

module pagerank_vertex_unit #(
	parameter int JOB_QUEUE_DEPTH = 8,
	parameter int CMD_FIFO_DEPTH  = 4
) (
	input  logic                               clock,
	input  logic                               rstn,
	input  pagerank_pkg::wb_job_req_t          job_req,
	output logic                               job_ack,
	output pagerank_pkg::wb_read_req_t         mem_req,
	input  logic                               mem_ack,
	input  pagerank_pkg::mem_word_u            mem_dat,
	output logic                               result_valid,
	output pagerank_pkg::vertex_result_t       result,
	output logic [pagerank_pkg::WORD_BITS-1:0] vertex_count,
	output logic [pagerank_pkg::WORD_BITS-1:0] edge_count
);
	import pagerank_pkg::*;

	logic                       job_valid;
	logic                       job_pop;
	vertex_job_t                job_head;
	logic                       count_clear;
	logic [EDGE_INDEX_BITS-1:0] out_degree;
	logic [EDGE_INDEX_BITS-1:0] issued_count;
	logic                       edges_issued_done;
	logic                       vertex_done;
	logic                       edge_cmd_valid;
	read_cmd_t                  edge_cmd;
	logic                       edge_cmd_taken;
	logic                       neighbour_valid;
	logic [VERTEX_ID_BITS-1:0]  neighbour_id;
	logic                       rank_slot_busy;
	logic                       cmd_pop;
	logic                       cmd_valid;
	read_cmd_t                  cmd_head;
	logic                       rank_valid;
	logic [RANK_BITS-1:0]       rank_value;
	logic [RANK_BITS-1:0]       sum;

	//////////////////////////////
	// Job side
	//////////////////////////////

	vertex_job_queue #(
		.JOB_QUEUE_DEPTH(JOB_QUEUE_DEPTH)
	) u_job_queue (
		.clock    (clock),
		.rstn     (rstn),
		.job_req  (job_req),
		.job_ack  (job_ack),
		.job_pop  (job_pop),
		.job_valid(job_valid),
		.job_head (job_head)
	);

	vertex_control u_control (
		.clock            (clock),
		.rstn             (rstn),
		.job_valid        (job_valid),
		.job_head         (job_head),
		.job_pop          (job_pop),
		.edges_issued_done(edges_issued_done),
		.vertex_done      (vertex_done),
		.issued_count     (issued_count),
		.out_degree       (out_degree),
		.count_clear      (count_clear),
		.edge_cmd_valid   (edge_cmd_valid),
		.edge_cmd         (edge_cmd),
		.sum              (sum),
		.result_valid     (result_valid),
		.result           (result)
	);

	edge_counter u_counter (
		.clock            (clock),
		.rstn             (rstn),
		.count_clear      (count_clear),
		.out_degree       (out_degree),
		.edge_cmd_taken   (edge_cmd_taken),
		.rank_valid       (rank_valid),
		.edges_issued_done(edges_issued_done),
		.vertex_done      (vertex_done),
		.issued_count     (issued_count),
		.vertex_count     (vertex_count),
		.edge_count       (edge_count)
	);

	rank_accumulator u_accumulator (
		.clock      (clock),
		.rstn       (rstn),
		.count_clear(count_clear),
		.rank_valid (rank_valid),
		.rank_value (rank_value),
		.sum        (sum)
	);

	//////////////////////////////
	// Memory side
	//////////////////////////////

	read_command_arbiter #(
		.CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
	) u_arbiter (
		.clock          (clock),
		.rstn           (rstn),
		.edge_cmd_valid (edge_cmd_valid),
		.edge_cmd       (edge_cmd),
		.edge_cmd_taken (edge_cmd_taken),
		.neighbour_valid(neighbour_valid),
		.neighbour_id   (neighbour_id),
		.rank_slot_busy (rank_slot_busy),
		.cmd_pop        (cmd_pop),
		.cmd_valid      (cmd_valid),
		.cmd_head       (cmd_head)
	);

	memory_read_port u_read_port (
		.clock          (clock),
		.rstn           (rstn),
		.cmd_pop        (cmd_pop),
		.cmd_valid      (cmd_valid),
		.cmd_head       (cmd_head),
		.rank_slot_busy (rank_slot_busy),
		.mem_req        (mem_req),
		.mem_ack        (mem_ack),
		.mem_dat        (mem_dat),
		.neighbour_valid(neighbour_valid),
		.neighbour_id   (neighbour_id),
		.rank_valid     (rank_valid),
		.rank_value     (rank_value)
	);

endmodule

`default_nettype wire

// File: verification/pagerank_vertex_unit_checker.sv
// Handshake assertions on the job and memory buses, bound into the vertex unit top level
`default_nettype none
`timescale 1ns/1ps

module pagerank_vertex_unit_checker (
	input logic                       clock,
	input logic                       rstn,
	input pagerank_pkg::wb_job_req_t  job_req,
	input logic                       job_ack,
	input pagerank_pkg::wb_read_req_t mem_req,
	input logic                       mem_ack,
	input logic                       result_valid
);

	int assertion_failures = 0;

	//////////////////////////////
	// Memory read bus
	//////////////////////////////

	mem_stb_within_cyc: assert property (@(posedge clock) disable iff (!rstn)
		mem_req.stb |-> mem_req.cyc)
		else begin
			$error("Memory stb is high without cyc");
			assertion_failures++;
		end

	// Master may not withdraw a read before its ack
	mem_stb_held: assert property (@(posedge clock) disable iff (!rstn)
		mem_req.stb && !mem_ack |=> mem_req.stb)
		else begin
			$error("Memory stb dropped before ack");
			assertion_failures++;
		end

	//////////////////////////////
	// Job bus and result
	//////////////////////////////

	result_single_pulse: assert property (@(posedge clock) disable iff (!rstn)
		result_valid |=> !result_valid)
		else begin
			$error("result_valid lasted more than one cycle");
			assertion_failures++;
		end

	job_ack_needs_stb: assert property (@(posedge clock) disable iff (!rstn)
		job_ack |-> $past(job_req.cyc && job_req.stb))
		else begin
			$error("job_ack raised without a host request");
			assertion_failures++;
		end

endmodule

bind pagerank_vertex_unit pagerank_vertex_unit_checker checker0 (
	.clock       (clock),
	.rstn        (rstn),
	.job_req     (job_req),
	.job_ack     (job_ack),
	.mem_req     (mem_req),
	.mem_ack     (mem_ack),
	.result_valid(result_valid)
);

`default_nettype wire

// File: verification/pagerank_vertex_unit_tb.sv
// Testbench for the PageRank vertex unit; run it as the simulation top with the checker bound in
`default_nettype none
`timescale 1ns/1ps

module pagerank_vertex_unit_tb;
	import pagerank_pkg::*;

	localparam int JOB_QUEUE_DEPTH = 8;
	localparam int CMD_FIFO_DEPTH  = 4;
	localparam int NUM_JOBS        = 40;
	localparam int IDLE_CYCLES     = 8;
	localparam int WATCHDOG_CYCLES = NUM_JOBS * 200;
	localparam int EDGE_WORDS      = 512;
	localparam int RANK_WORDS      = 256;
	localparam logic [31:0] LFSR_SEED = 32'h2e6e184f;
	// Taps 32 22 2 1
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic                 clock;
	logic                 rstn;
	wb_job_req_t          job_req;
	logic                 job_ack;
	wb_read_req_t         mem_req;
	logic                 mem_ack;
	mem_word_u            mem_dat;
	logic                 result_valid;
	vertex_result_t       result;
	logic [WORD_BITS-1:0] vertex_count;
	logic [WORD_BITS-1:0] edge_count;

	logic [31:0]    lfsr_state;
	logic [31:0]    edge_mem [EDGE_WORDS];
	logic [31:0]    rank_mem [RANK_WORDS];
	vertex_job_t    jobs [NUM_JOBS];
	vertex_job_t    expected_jobs [$];
	int             results_seen = 0;
	logic [31:0]    edges_expected = '0;
	logic           stall_seen = 1'b0;
	int             result_errors = 0;
	int             count_errors = 0;
	int             flag_errors = 0;
	int             other_errors = 0;

	pagerank_vertex_unit #(
		.JOB_QUEUE_DEPTH(JOB_QUEUE_DEPTH),
		.CMD_FIFO_DEPTH (CMD_FIFO_DEPTH)
	) dut0 (
		.clock       (clock),
		.rstn        (rstn),
		.job_req     (job_req),
		.job_ack     (job_ack),
		.mem_req     (mem_req),
		.mem_ack     (mem_ack),
		.mem_dat     (mem_dat),
		.result_valid(result_valid),
		.result      (result),
		.vertex_count(vertex_count),
		.edge_count  (edge_count)
	);

	always #10 clock = ~clock;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
		end
		return value;
	endfunction

	// Wrapping sum of the ranks of all neighbours of the job
	function automatic logic [RANK_BITS-1:0] reference_sum(input vertex_job_t job);
		logic [RANK_BITS-1:0] total;
		logic [15:0]          neighbour;
		total = '0;
		for (int k = 0; k < int'(job.out_degree); k++) begin
			neighbour = edge_mem[int'(job.edge_start) + k][15:0];
			total     = total + rank_mem[neighbour[7:0]];
		end
		return total;
	endfunction

	function automatic mem_word_u memory_word(input read_cmd_t adr);
		mem_word_u word;
		word = '0;
		if (adr.kind == RANK_ARRAY) begin
			word.rank_view = rank_mem[adr.index[7:0]];
		end else begin
			word = mem_word_u'(edge_mem[adr.index[8:0]]);
		end
		return word;
	endfunction

	task automatic compare_result(input string name, input vertex_result_t expected,
			input vertex_result_t actual);
		if (actual !== expected) begin
			result_errors++;
			$display("[ERROR] %s: expected id %h sum %h, actual id %h sum %h", name,
				expected.vertex_id, expected.sum, actual.vertex_id, actual.sum);
		end
	endtask

	task automatic verify_counts(input string name, input logic [WORD_BITS-1:0] exp_vertices,
			input logic [WORD_BITS-1:0] exp_edges, input logic [WORD_BITS-1:0] act_vertices,
			input logic [WORD_BITS-1:0] act_edges);
		if (act_vertices !== exp_vertices || act_edges !== exp_edges) begin
			count_errors++;
			$display("[ERROR] %s: expected vertices %0d edges %0d, actual vertices %0d edges %0d",
				name, exp_vertices, exp_edges, act_vertices, act_edges);
		end
	endtask

	task automatic expect_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			flag_errors++;
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	// Holds the job on the bus until acked; leaves stb up for the next one
	task automatic send_job(input vertex_job_t job);
		int waited;
		waited = 0;
		job_req.cyc = 1'b1;
		job_req.stb = 1'b1;
		job_req.dat = job;
		expected_jobs.push_back(job);
		do begin
			@(negedge clock);
			waited++;
		end while (!job_ack);
		// Previous ack already costs one cycle
		if (waited > 2) begin
			stall_seen = 1'b1;
		end
	endtask

	//////////////////////////////
	// Memory model
	//////////////////////////////

	initial begin : memory_model
		int delay;
		forever begin
			@(negedge clock);
			mem_ack = 1'b0;
			if (rstn && mem_req.cyc && mem_req.stb) begin
				if ((mem_req.adr.kind == RANK_ARRAY && mem_req.adr.index >= RANK_WORDS) ||
						(mem_req.adr.kind == EDGE_ARRAY && mem_req.adr.index >= EDGE_WORDS)) begin
					other_errors++;
					$display("Memory read outside the filled range at index %0d", mem_req.adr.index);
				end
				delay = int'(random_bits(2));
				repeat (delay) @(negedge clock);
				mem_dat = memory_word(mem_req.adr);
				mem_ack = 1'b1;
			end
		end
	end

	//////////////////////////////
	// Result monitor
	//////////////////////////////

	initial begin : result_monitor
		vertex_job_t    job;
		vertex_result_t expected;
		forever begin
			@(negedge clock);
			if (rstn && result_valid) begin
				if (expected_jobs.size() == 0) begin
					other_errors++;
					$display("A result came out while no job was outstanding");
				end else begin
					job = expected_jobs.pop_front();
					expected.vertex_id = job.vertex_id;
					expected.sum       = reference_sum(job);
					results_seen++;
					edges_expected = edges_expected + 32'(job.out_degree);
					compare_result($sformatf("result %0d", results_seen - 1), expected, result);
					verify_counts($sformatf("counts after result %0d", results_seen - 1),
						32'(results_seen), edges_expected, vertex_count, edge_count);
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Timeout: the jobs did not all finish within %0d cycles", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin : stimulus
		lfsr_state = LFSR_SEED;
		clock      = 1'b0;
		rstn       = 1'b0;
		job_req    = '0;
		mem_ack    = 1'b0;
		mem_dat    = '0;
		// Edge words carry random padding above the id
		for (int i = 0; i < EDGE_WORDS; i++) begin
			edge_mem[i] = random_bits(32) & 32'hffff_00ff;
		end
		for (int i = 0; i < RANK_WORDS; i++) begin
			rank_mem[i] = random_bits(32);
		end
		for (int i = 0; i < NUM_JOBS; i++) begin
			jobs[i].vertex_id  = 16'(random_bits(16));
			jobs[i].edge_start = 16'(random_bits(8));
			jobs[i].out_degree = 16'(random_bits(3));
		end
		// Edgeless vertex followed by a normal one
		jobs[1].out_degree = '0;
		if (jobs[2].out_degree == '0) begin
			jobs[2].out_degree = 16'd4;
		end
		repeat (4) @(negedge clock);
		rstn = 1'b1;
		repeat (IDLE_CYCLES) begin
			@(negedge clock);
			expect_flag("idle result_valid", 1'b0, result_valid);
			expect_flag("idle mem cyc", 1'b0, mem_req.cyc);
			expect_flag("idle job_ack", 1'b0, job_ack);
			verify_counts("idle counts", '0, '0, vertex_count, edge_count);
		end
		// Back to back burst, deeper than the job queue
		for (int i = 0; i < NUM_JOBS; i++) begin
			send_job(jobs[i]);
		end
		job_req.cyc = 1'b0;
		job_req.stb = 1'b0;
		wait (results_seen == NUM_JOBS);
		repeat (20) @(negedge clock);
		if (!stall_seen) begin
			other_errors++;
			$display("The job queue never held off the host during the burst");
		end
		$display("Errors: %0d result, %0d count, %0d flag, %0d other, %0d assertion",
			result_errors, count_errors, flag_errors, other_errors,
			dut0.checker0.assertion_failures);
		if (result_errors + count_errors + flag_errors + other_errors +
				dut0.checker0.assertion_failures == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
source/pagerank_pkg.sv
source/vertex_job_queue.sv
source/vertex_control.sv
source/edge_counter.sv
source/read_command_arbiter.sv
source/memory_read_port.sv
source/rank_accumulator.sv
source/pagerank_vertex_unit.sv
verification/pagerank_vertex_unit_checker.sv
verification/pagerank_vertex_unit_tb.sv

// File: Bender.yml
package:
  name: pagerank_vertex_unit

sources:
  - files:
      - source/pagerank_pkg.sv
      - source/vertex_job_queue.sv
      - source/vertex_control.sv
      - source/edge_counter.sv
      - source/read_command_arbiter.sv
      - source/memory_read_port.sv
      - source/rank_accumulator.sv
      - source/pagerank_vertex_unit.sv
  - target: test
    files:
      - verification/pagerank_vertex_unit_checker.sv
      - verification/pagerank_vertex_unit_tb.sv
